/* bench/mboxCtlTb.sv */
`timescale 1ns/10ps
`include "mbox_defs.svh"

module mboxCtlTb;

  logic clk = 1'b0;
  logic arstN = 1'b1;
  logic coreRdRq = 1'b0;
  logic writebackRq = 1'b0;
  logic chanRdRq = 1'b0;
  logic [`MBOX_ADR_W-1:0] pma = '0;
  logic [`MBOX_RQ_WORDS-1:0] wordMask = '0;
  logic memAcknA = 1'b0;
  logic memAcknB = 1'b0;
  logic memDataValidA = 1'b0;
  logic memDataValidB = 1'b0;
  logic nxmAckn = 1'b0;
  logic forceBadPar = 1'b0;
  logic diagRead = 1'b0;
  mboxDiagPkg::diagGroup diagSel = mboxDiagPkg::diagRequest;
  logic memStartA;
  logic memStartB;
  logic memAdrPar;
  logic coreDataValid;
  logic coreBusy;
  logic [`MBOX_DIAG_W-1:0] ebusData;

  logic phaseA;
  logic expRead = 1'b0;
  logic busySeen = 1'b0;
  logic [`MBOX_DV_DELAY-1:0] dvHist = '0;
  int acksLeft = 0;
  int errors = 0;
  int timeouts = 0;
  integer seed = 32'h74604770;
  logic [`MBOX_ADR_W-1:0] lastAdr = '0;
  logic [`MBOX_RQ_WORDS-1:0] lastWords = '0;
  logic lastRead = 1'b0;
  logic lastPar = 1'b0;

  mboxCtl mboxCtl_inst (.*);

  bind mboxCtl mboxCtl_sva svaInst (
    .clk(clk), .arstN(arstN), .memStartA(memStartA), .memStartB(memStartB),
    .memStart(memStart), .rqHold(rqHold), .startPending(startPending),
    .lastAckn(lastAckn), .acknPulse(acknPulse), .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing), .memDataValidA(memDataValidA),
    .memDataValidB(memDataValidB), .coreDataValid(coreDataValid), .coreBusy(coreBusy)
  );

  always #10 clk = ~clk;

  // Own copy of the phase, A first after reset
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      phaseA <= 1'b1;
    end else begin
      phaseA <= ~phaseA;
    end
  end

  // Memory model answers one word per own phase cycle
  always @(posedge clk) begin
    #2;
    checkValue("coreDataValid delay", dvHist[`MBOX_DV_DELAY-1], coreDataValid);
    busySeen = busySeen | coreBusy;
    memAcknA = 1'b0;
    memAcknB = 1'b0;
    nxmAckn = 1'b0;
    if (acksLeft > 0 && (memStartA && phaseA || memStartB && !phaseA)) begin
      memAcknA = phaseA & expRead;
      memAcknB = !phaseA & expRead;
      // Writebacks are answered as nonexistent memory
      nxmAckn = !expRead;
      acksLeft--;
    end else if (memStartA || memStartB) begin
      // Strobes of the other phase, to be ignored
      memAcknA = !phaseA;
      memAcknB = phaseA;
    end
    memDataValidA = memAcknA;
    memDataValidB = memAcknB;
    dvHist = {dvHist[`MBOX_DV_DELAY-2:0], memDataValidA & phaseA | memDataValidB & !phaseA};
  end

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic waitStart(input int limit);
    int n;
    n = 0;
    while (!(memStartA || memStartB) && n < limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!(memStartA || memStartB)) begin
      $display("Timeout: no memory start within %0d cycles", limit);
      timeouts++;
    end
  endtask

  task automatic waitIdle(input int limit);
    int n;
    n = 0;
    while ((memStartA || memStartB || mboxCtl_inst.rqHold) && n < limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (memStartA || memStartB || mboxCtl_inst.rqHold) begin
      $display("Timeout: request still outstanding after %0d cycles", limit);
      timeouts++;
    end
  endtask

  task automatic runRequest(input int kind, input logic [`MBOX_ADR_W-1:0] adr,
                            input logic [`MBOX_RQ_WORDS-1:0] mask, input logic bad,
                            input logic dropNext);
    logic [`MBOX_RQ_WORDS-1:0] words;
    logic rd;
    logic expPar;
    words = (kind == 0) ? (mask | 4'b0001) : mask;
    rd = (kind != 1);
    expPar = ~(^adr) ^ rd ^ (kind == 1) ^ (^words) ^ bad;
    acksLeft = $countones(words);
    expRead = rd;
    busySeen = 1'b0;
    pma = adr;
    wordMask = mask;
    forceBadPar = bad;
    coreRdRq = (kind == 0);
    writebackRq = (kind == 1);
    chanRdRq = (kind == 2);
    @(posedge clk);
    #2;
    {coreRdRq, writebackRq, chanRdRq, forceBadPar} = '0;
    waitStart(5);
    checkValue("start phase", !phaseA, memStartA);
    checkValue("address parity", expPar, memAdrPar);
    // A second event while the request is held must be lost
    if (dropNext) begin
      pma = ~adr;
      wordMask = ~mask;
      writebackRq = 1'b1;
      @(posedge clk);
      #2;
      writebackRq = 1'b0;
    end
    waitIdle(40);
    checkValue("dropped event", 0, mboxCtl_inst.startReq);
    checkValue("acks before end", 0, acksLeft);
    checkValue("coreBusy span", rd && $countones(words) > 1, busySeen);
    lastAdr = adr;
    lastWords = words;
    lastRead = rd;
    lastPar = expPar ^ bad;
  endtask

  function automatic logic [`MBOX_DIAG_W-1:0] diagExpect(input int g);
    case (g)
      0: return {lastRead, !lastRead, 1'b0, lastWords};
      1: return 7'b0001000;
      2: return {phaseA, !phaseA, lastPar, 2'b00, lastAdr[1:0]};
      3: return lastAdr[8:2];
      default: return '0;
    endcase
  endfunction

  task automatic checkDiag(input logic rd, input int g);
    diagRead = rd;
    diagSel = mboxDiagPkg::diagGroup'(g[2:0]);
    #5;
    checkValue($sformatf("diag group %0d read %0d", g, rd),
               rd ? diagExpect(g) : '0, ebusData);
  endtask

  initial begin
    int kind;
    #1;
    arstN = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arstN = 1'b1;
    checkValue("reset outputs", 0,
               {memStartA, memStartB, mboxCtl_inst.rqHold, coreDataValid, coreBusy});
    checkValue("first phase", 1, mboxCtl_inst.aChangeComing);

    runRequest(0, 9'h1a5, 4'b1010, 1'b0, 1'b0);
    runRequest(1, 9'h0f3, 4'b1111, 1'b1, 1'b0);
    runRequest(2, 9'h04c, 4'b0110, 1'b0, 1'b1);
    for (int i = 0; i < 8; i++) begin
      kind = $unsigned($random(seed)) % 3;
      runRequest(kind, $random(seed), $random(seed), $random(seed), i[0]);
    end

    // Status groups while idle, then with diagRead low
    for (int g = 0; g < 8; g++) begin
      @(posedge clk);
      #2;
      checkDiag(1'b1, g);
    end
    @(posedge clk);
    #2;
    checkDiag(1'b0, 0);

    $display("Done: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* bench/mboxCtl_sva.sv */
`timescale 1ns/10ps
`include "mbox_defs.svh"

module mboxCtl_sva (
  input logic clk,
  input logic arstN,
  input logic memStartA,
  input logic memStartB,
  input logic memStart,
  input logic rqHold,
  input logic startPending,
  input logic lastAckn,
  input logic acknPulse,
  input logic aChangeComing,
  input logic bChangeComing,
  input logic memDataValidA,
  input logic memDataValidB,
  input logic coreDataValid,
  input logic coreBusy
);

  logic dvQual;

  assign dvQual = memDataValidA & aChangeComing | memDataValidB & bChangeComing;

  resetQuiet: assert property (@(posedge clk)
    !arstN |-> !memStartA && !memStartB && !rqHold && !coreDataValid)
    else $error("outputs active during reset");

  // A phase leads after reset, then strict alternation
  firstPhase: assert property (@(posedge clk) $rose(arstN) |-> aChangeComing)
    else $error("first phase after reset is not A");
  phaseAtoB: assert property (@(posedge clk) disable iff (!arstN)
    aChangeComing |=> bChangeComing && !aChangeComing)
    else $error("phase did not move from A to B");
  phaseBtoA: assert property (@(posedge clk) disable iff (!arstN)
    bChangeComing |=> aChangeComing && !bChangeComing)
    else $error("phase did not move from B to A");

  startExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(memStartA && memStartB))
    else $error("memStartA and memStartB high together");
  startPrompt: assert property (@(posedge clk) disable iff (!arstN)
    startPending && !memStart && aChangeComing |=> memStartA)
    else $error("memStartA missed its phase change");
  startPhaseB: assert property (@(posedge clk) disable iff (!arstN)
    $rose(memStartB) |-> $past(bChangeComing))
    else $error("memStartB rose outside a B change");

  endAfterAcks: assert property (@(posedge clk) disable iff (!arstN)
    $fell(memStartA) |-> $past(lastAckn && aChangeComing))
    else $error("memStartA fell before the last acknowledge");
  endAfterAcksB: assert property (@(posedge clk) disable iff (!arstN)
    $fell(memStartB) |-> $past(lastAckn && bChangeComing))
    else $error("memStartB fell before the last acknowledge");
  holdRelease: assert property (@(posedge clk) disable iff (!arstN)
    $fell(memStart) |-> rqHold ##1 !rqHold)
    else $error("rqHold did not end one cycle after memStart");

  acknOutstanding: assert property (@(posedge clk) disable iff (!arstN)
    acknPulse |-> !lastAckn)
    else $error("acknowledge with no word outstanding");
  dvDelay: assert property (@(posedge clk) disable iff (!arstN)
    coreDataValid == $past(dvQual, `MBOX_DV_DELAY))
    else $error("coreDataValid off its data valid delay");
  busyInHold: assert property (@(posedge clk) disable iff (!arstN) coreBusy |-> rqHold)
    else $error("coreBusy outside a held request");

endmodule

/* logic/mboxBusPkg.sv */
package mboxBusPkg;

  // Cause of a memory start
  typedef enum logic [1:0] {
    kindCoreRd    = 2'd0,
    kindWriteback = 2'd1,
    kindChanRd    = 2'd2
  } startKind;

  // Bus phase whose change is coming next
  typedef enum logic {
    phaseA = 1'b0,
    phaseB = 1'b1
  } busPhase;

endpackage

/* logic/mboxCtl.sv */
`timescale 1ns/10ps
`include "mbox_defs.svh"

module mboxCtl (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      coreRdRq,
  input  logic                      writebackRq,
  input  logic                      chanRdRq,
  input  logic [`MBOX_ADR_W-1:0]    pma,
  input  logic [`MBOX_RQ_WORDS-1:0] wordMask,
  input  logic                      memAcknA,
  input  logic                      memAcknB,
  input  logic                      memDataValidA,
  input  logic                      memDataValidB,
  input  logic                      nxmAckn,
  input  logic                      forceBadPar,
  input  logic                      diagRead,
  input  mboxDiagPkg::diagGroup     diagSel,
  output logic                      memStartA,
  output logic                      memStartB,
  output logic                      memAdrPar,
  output logic                      coreDataValid,
  output logic                      coreBusy,
  output logic [`MBOX_DIAG_W-1:0]   ebusData
);

  logic                      startReq;
  logic [`MBOX_ADR_W-1:0]    startAdr;
  logic [`MBOX_RQ_WORDS-1:0] startWords;
  logic                      startRead;
  logic                      startWrite;
  logic                      startPar;
  logic                      rqHold;
  logic                      startPending;
  logic [`MBOX_RQ_WORDS-1:0] memRq;
  logic [`MBOX_ADR_W-1:0]    memAdr;
  logic                      memRead;
  logic                      memWrite;
  logic                      parHold;
  logic                      lastAckn;
  logic                      acknPulse;
  logic                      memStart;
  logic                      aChangeComing;
  logic                      bChangeComing;

  mboxReqSource reqSourceInst (
    .clk(clk), .arstN(arstN),
    .coreRdRq(coreRdRq), .writebackRq(writebackRq), .chanRdRq(chanRdRq),
    .pma(pma), .wordMask(wordMask), .rqHold(rqHold),
    .startReq(startReq), .startAdr(startAdr), .startWords(startWords),
    .startRead(startRead), .startWrite(startWrite), .startPar(startPar),
    .startCause()
  );

  mboxRqHold rqHoldInst (
    .clk(clk), .arstN(arstN),
    .startReq(startReq), .startAdr(startAdr), .startWords(startWords),
    .startRead(startRead), .startWrite(startWrite), .startPar(startPar),
    .acknPulse(acknPulse), .memStart(memStart),
    .rqHold(rqHold), .startPending(startPending), .memRq(memRq), .memAdr(memAdr),
    .memRead(memRead), .memWrite(memWrite), .parHold(parHold),
    .lastAckn(lastAckn), .wordsLeft()
  );

  mboxPhaseCtl phaseCtlInst (
    .clk(clk), .arstN(arstN),
    .startPending(startPending), .lastAckn(lastAckn), .memRq(memRq),
    .memRead(memRead), .memWrite(memWrite), .parHold(parHold),
    .memAcknA(memAcknA), .memAcknB(memAcknB), .nxmAckn(nxmAckn),
    .memDataValidA(memDataValidA), .memDataValidB(memDataValidB),
    .forceBadPar(forceBadPar),
    .memStartA(memStartA), .memStartB(memStartB), .memStart(memStart),
    .acknPulse(acknPulse), .memAdrPar(memAdrPar), .coreDataValid(coreDataValid),
    .coreBusy(coreBusy), .aChangeComing(aChangeComing), .bChangeComing(bChangeComing)
  );

  mboxDiagMux diagMuxInst (
    .diagRead(diagRead), .diagSel(diagSel),
    .memRq(memRq), .memRead(memRead), .memWrite(memWrite), .rqHold(rqHold),
    .memStartA(memStartA), .memStartB(memStartB), .acknPulse(acknPulse),
    .coreBusy(coreBusy), .coreDataValid(coreDataValid),
    .aChangeComing(aChangeComing), .bChangeComing(bChangeComing),
    .memAdr(memAdr), .memAdrPar(memAdrPar), .lastAckn(lastAckn),
    .ebusData(ebusData)
  );

endmodule

/* logic/mboxDiagMux.sv */
`timescale 1ns/10ps
`include "mbox_defs.svh"

module mboxDiagMux (
  input  logic                      diagRead,
  input  mboxDiagPkg::diagGroup     diagSel,
  input  logic [`MBOX_RQ_WORDS-1:0] memRq,
  input  logic                      memRead,
  input  logic                      memWrite,
  input  logic                      rqHold,
  input  logic                      memStartA,
  input  logic                      memStartB,
  input  logic                      acknPulse,
  input  logic                      coreBusy,
  input  logic                      coreDataValid,
  input  logic                      aChangeComing,
  input  logic                      bChangeComing,
  input  logic [`MBOX_ADR_W-1:0]    memAdr,
  input  logic                      memAdrPar,
  input  logic                      lastAckn,
  output logic [`MBOX_DIAG_W-1:0]   ebusData
);

  always_comb begin
    ebusData = '0;
    if (diagRead) begin
      case (diagSel)
        mboxDiagPkg::diagRequest:
          ebusData = {memRead, memWrite, rqHold, memRq};
        mboxDiagPkg::diagStart:
          ebusData = {memStartA, memStartB, acknPulse, lastAckn,
                      coreBusy, coreDataValid, 1'b0};
        mboxDiagPkg::diagPhase:
          ebusData = {aChangeComing, bChangeComing, memAdrPar, 2'b00, memAdr[1:0]};
        mboxDiagPkg::diagAddress:
          ebusData = memAdr[8:2];
        default:
          ebusData = '0;
      endcase
    end
  end

endmodule

/* logic/mboxDiagPkg.sv */
package mboxDiagPkg;

  // Bit placement on the 7-bit field, msb first
  // Request  memRead, memWrite, rqHold, memRq[3:0]
  // Start    memStartA, memStartB, acknPulse, lastAckn, coreBusy, coreDataValid, 0
  // Phase    aChangeComing, bChangeComing, memAdrPar, 0, 0, memAdr[1:0]
  // Address  memAdr[8:2]
  // Spare codes read zero
  typedef enum logic [2:0] {
    diagRequest = 3'd0,
    diagStart   = 3'd1,
    diagPhase   = 3'd2,
    diagAddress = 3'd3
  } diagGroup;

endpackage

/* logic/mboxPhaseCtl.sv */
`timescale 1ns/10ps
`include "mbox_defs.svh"

module mboxPhaseCtl (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      startPending,
  input  logic                      lastAckn,
  input  logic [`MBOX_RQ_WORDS-1:0] memRq,
  input  logic                      memRead,
  input  logic                      memWrite,
  input  logic                      parHold,
  input  logic                      memAcknA,
  input  logic                      memAcknB,
  input  logic                      nxmAckn,
  input  logic                      memDataValidA,
  input  logic                      memDataValidB,
  input  logic                      forceBadPar,
  output logic                      memStartA,
  output logic                      memStartB,
  output logic                      memStart,
  output logic                      acknPulse,
  output logic                      memAdrPar,
  output logic                      coreDataValid,
  output logic                      coreBusy,
  output logic                      aChangeComing,
  output logic                      bChangeComing
);

  localparam int cntW = $clog2(`MBOX_RQ_WORDS + 1);

  mboxBusPkg::busPhase       comingPhase;
  logic                      setA;
  logic                      setB;
  logic                      clrA;
  logic                      clrB;
  logic                      dvQualified;
  logic [`MBOX_DV_DELAY-1:0] dvPipe;
  logic [cntW-1:0]           dvLeft;
  logic                      badPar;

  function automatic logic [cntW-1:0] countWords(input logic [`MBOX_RQ_WORDS-1:0] mask);
    logic [cntW-1:0] total;
    total = '0;
    for (int i = 0; i < `MBOX_RQ_WORDS; i++) begin
      total = total + cntW'(mask[i]);
    end
    return total;
  endfunction

  // A change comes first out of reset, then alternate
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      comingPhase <= mboxBusPkg::phaseA;
    end else if (comingPhase == mboxBusPkg::phaseA) begin
      comingPhase <= mboxBusPkg::phaseB;
    end else begin
      comingPhase <= mboxBusPkg::phaseA;
    end
  end

  assign aChangeComing = (comingPhase == mboxBusPkg::phaseA);
  assign bChangeComing = (comingPhase == mboxBusPkg::phaseB);

  // First phase change after the request owns it
  assign setA = startPending & aChangeComing & ~memStart;
  assign setB = startPending & bChangeComing & ~memStart;
  assign clrA = memStartA & aChangeComing & lastAckn;
  assign clrB = memStartB & bChangeComing & lastAckn;

  assign memStart  = memStartA | memStartB;
  assign acknPulse = memStart & ((memAcknA | nxmAckn) & aChangeComing |
                                 (memAcknB | nxmAckn) & bChangeComing);
  assign dvQualified = memDataValidA & aChangeComing | memDataValidB & bChangeComing;
  assign coreDataValid = dvPipe[`MBOX_DV_DELAY-1];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memStartA <= 1'b0;
      memStartB <= 1'b0;
      dvPipe    <= '0;
      dvLeft    <= '0;
      coreBusy  <= 1'b0;
      badPar    <= 1'b0;
    end else begin
      memStartA <= setA | memStartA & ~clrA;
      memStartB <= setB | memStartB & ~clrB;
      dvPipe    <= {dvPipe[`MBOX_DV_DELAY-2:0], dvQualified};

      // Data words still expected by the core
      if (setA | setB) begin
        dvLeft <= memRead ? countWords(memRq) : '0;
      end else if (coreDataValid && dvLeft != '0) begin
        dvLeft <= dvLeft - 1'b1;
      end

      if (coreDataValid) begin
        coreBusy <= (dvLeft > cntW'(1));
      end

      // Armed while idle, spent when the request ends
      if (clrA | clrB) begin
        badPar <= 1'b0;
      end else if (forceBadPar & ~memStart) begin
        badPar <= 1'b1;
      end
    end
  end

  assign memAdrPar = parHold ^ memRead ^ memWrite ^ (^memRq) ^ badPar;

endmodule

/* logic/mboxReqSource.sv */
`timescale 1ns/10ps
`include "mbox_defs.svh"

module mboxReqSource (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      coreRdRq,
  input  logic                      writebackRq,
  input  logic                      chanRdRq,
  input  logic [`MBOX_ADR_W-1:0]    pma,
  input  logic [`MBOX_RQ_WORDS-1:0] wordMask,
  input  logic                      rqHold,
  output logic                      startReq,
  output logic [`MBOX_ADR_W-1:0]    startAdr,
  output logic [`MBOX_RQ_WORDS-1:0] startWords,
  output logic                      startRead,
  output logic                      startWrite,
  output logic                      startPar,
  output mboxBusPkg::startKind      startCause
);

  localparam logic [`MBOX_RQ_WORDS-1:0] firstWordMask = 1;

  logic                      anyEvent;
  logic                      accept;
  logic                      captured;
  mboxBusPkg::startKind      eventKind;
  logic [`MBOX_RQ_WORDS-1:0] eventWords;

  // Core read first, then writeback, then channel read
  always_comb begin
    anyEvent = coreRdRq | writebackRq | chanRdRq;
    if (coreRdRq) begin
      eventKind = mboxBusPkg::kindCoreRd;
    end else if (writebackRq) begin
      eventKind = mboxBusPkg::kindWriteback;
    end else begin
      eventKind = mboxBusPkg::kindChanRd;
    end
  end

  // Word 0 leads every core read
  assign eventWords = (eventKind == mboxBusPkg::kindCoreRd) ?
                      (wordMask | firstWordMask) : wordMask;

  // Events while a request is pending or held are dropped
  assign accept   = anyEvent & ~startReq & ~rqHold;
  assign captured = startReq & ~rqHold;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      startReq <= 1'b0;
    end else if (accept) begin
      startReq <= 1'b1;
    end else if (captured) begin
      startReq <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      startAdr   <= pma;
      startWords <= eventWords;
      startCause <= eventKind;
      startRead  <= (eventKind != mboxBusPkg::kindWriteback);
      startWrite <= (eventKind == mboxBusPkg::kindWriteback);
    end
  end

  // Odd parity over the address slice
  assign startPar = ~^startAdr;

endmodule

/* logic/mboxRqHold.sv */
`timescale 1ns/10ps
`include "mbox_defs.svh"

module mboxRqHold (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      startReq,
  input  logic [`MBOX_ADR_W-1:0]    startAdr,
  input  logic [`MBOX_RQ_WORDS-1:0] startWords,
  input  logic                      startRead,
  input  logic                      startWrite,
  input  logic                      startPar,
  input  logic                      acknPulse,
  input  logic                      memStart,
  output logic                      rqHold,
  output logic                      startPending,
  output logic [`MBOX_RQ_WORDS-1:0] memRq,
  output logic [`MBOX_ADR_W-1:0]    memAdr,
  output logic                      memRead,
  output logic                      memWrite,
  output logic                      parHold,
  output logic                      lastAckn,
  output logic [`MBOX_RQ_WORDS-1:0] wordsLeft
);

  logic capture;
  logic memStartQ;
  logic memStartFell;

  assign capture      = startReq & ~rqHold;
  assign memStartFell = memStartQ & ~memStart;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rqHold       <= 1'b0;
      startPending <= 1'b0;
      memStartQ    <= 1'b0;
      wordsLeft    <= '0;
    end else begin
      memStartQ <= memStart;

      if (capture) begin
        rqHold <= 1'b1;
      end else if (memStartFell) begin
        rqHold <= 1'b0;
      end

      // Pending until the start flop is seen
      if (capture) begin
        startPending <= 1'b1;
      end else if (memStart) begin
        startPending <= 1'b0;
      end

      // Retire lowest outstanding word per acknowledge
      if (capture) begin
        wordsLeft <= startWords;
      end else if (acknPulse) begin
        wordsLeft <= wordsLeft & (wordsLeft - 1'b1);
      end
    end
  end

  // Request registers, loaded once per request
  always_ff @(posedge clk) begin
    if (capture) begin
      memRq    <= startWords;
      memAdr   <= startAdr;
      memRead  <= startRead;
      memWrite <= startWrite;
      parHold  <= startPar;
    end
  end

  assign lastAckn = ~|wordsLeft;

endmodule

/* logic/mbox_defs.svh */
`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// Physical address slice, bits 27 to 35
`define MBOX_ADR_W 9

// Word request bits per memory request
`define MBOX_RQ_WORDS 4

// Memory data valid to core data valid, in cycles (two or more)
`define MBOX_DV_DELAY 2

// Diagnostic bus field
`define MBOX_DIAG_W 7

`endif

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mboxCtlTb -f vlog.f -o mboxSim
./obj_dir/mboxSim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

/* vlog.f */
+incdir+logic
logic/mboxBusPkg.sv
logic/mboxDiagPkg.sv
logic/mboxReqSource.sv
logic/mboxRqHold.sv
logic/mboxPhaseCtl.sv
logic/mboxDiagMux.sv
logic/mboxCtl.sv
bench/mboxCtl_sva.sv
bench/mboxCtlTb.sv
